// File: Bender.yml
package:
  name: video_out

sources:
  - include_dirs:
      - include
    files:
      - design/video_pkg.sv
      - design/video_regs.sv
      - design/video_cram.sv
      - design/video_pixel_sel.sv
      - design/video_dither.sv
      - design/video_out_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/video_out_checker.sv
      - tb/video_out_tb.sv

// File: design/video_cram.sv
// Colour RAM

`default_nettype none
`timescale 1ns/1ns

`include "video_params.svh"

module video_cram
	import video_pkg::*;
(
	input  wire             clk,
	input  wire             a_we,
	input  wire pix_index_t a_addr,
	input  wire pal_entry_t a_wdata,
	output pal_entry_t      a_rdata,
	input  wire pix_index_t b_addr,
	output pal_entry_t      b_rdata
);

	pal_entry_t mem [`VIDEO_CRAM_DEPTH];

	// port a, CPU side, read before write
	always_ff @(posedge clk)
	begin
		if (a_we)
			mem[a_addr] <= a_wdata;
		a_rdata <= mem[a_addr];
	end

	// port b, video side
	// a same-cycle write to this entry shows up a cycle later
	always_ff @(posedge clk)
	begin
		b_rdata <= mem[b_addr];
	end

endmodule

`default_nettype wire

// File: design/video_dither.sv
// Video PWM dither stage

`default_nettype none
`timescale 1ns/1ns

module video_dither
	import video_pkg::*;
(
	input  wire             clk,
	input  wire             reset,
	input  wire             vga_on,
	input  wire pal_entry_t entry,
	input  wire             blank_q,
	input  wire             line_q,
	output logic      [1:0] vred,
	output logic      [1:0] vgrn,
	output logic      [1:0] vblu
);

	logic [2:0] phase_cnt;
	logic [2:0] phase;

	// dither pattern per fine intensity, bit n is used at phase n
	function automatic logic [7:0] pwm_pattern(input logic [2:0] fine);
		case (fine)
			3'd0:    return 8'h00;
			3'd1:    return 8'h01;
			3'd2:    return 8'h41;
			3'd3:    return 8'h45;
			3'd4:    return 8'ha5;
			3'd5:    return 8'ha7;
			3'd6:    return 8'hd7;
			default: return 8'hdf;
		endcase
	endfunction

	// coarse plus one on set phases, saturating at 3
	function automatic logic [1:0] dith_level(
		input logic [1:0] coarse,
		input logic [2:0] fine,
		input logic [2:0] ph
	);
		logic [7:0] pat;
		pat = pwm_pattern(fine);
		if (pat[ph] && (coarse != 2'd3))
			return coarse + 2'd1;
		return coarse;
	endfunction

	always_ff @(posedge clk)
	begin
		if (reset)
			phase_cnt <= 3'd0;
		else
			phase_cnt <= phase_cnt + 3'd1;
	end

	// in VGA the line parity spreads the pattern over two doubled lines
	assign phase = vga_on ? {line_q, phase_cnt[1:0]} : phase_cnt;

	always_ff @(posedge clk)
	begin
		if (reset || blank_q)
		begin
			vred <= 2'd0;
			vgrn <= 2'd0;
			vblu <= 2'd0;
		end
		else
		begin
			vred <= dith_level(entry.r_coarse, entry.r_fine, phase);
			vgrn <= dith_level(entry.g_coarse, entry.g_fine, phase);
			vblu <= dith_level(entry.b_coarse, entry.b_fine, phase);
		end
	end

endmodule

`default_nettype wire

// File: design/video_out_top.sv
// Video output stage top

`default_nettype none
`timescale 1ns/1ns

module video_out_top
	import video_pkg::*;
(
	input  wire         clk,
	input  wire         reset,
	input  wire  [11:0] paddr,
	input  wire         psel,
	input  wire         penable,
	input  wire         pwrite,
	input  wire  [31:0] pwdata,
	output wire  [31:0] prdata,
	output wire         pready,
	output wire         pslverr,
	input  wire         pix_en,
	input  wire         start_out,
	input  wire   [7:0] tv_data,
	input  wire   [7:0] vga_data,
	input  wire         tv_hblank,
	input  wire         tv_vblank,
	input  wire         vga_hblank,
	input  wire         vga_line,
	output wire   [1:0] vred,
	output wire   [1:0] vgrn,
	output wire   [1:0] vblu
);

	wire             vga_on;
	wire             hires;
	wire             cram_we;
	wire pix_index_t cram_addr;
	wire pal_entry_t cram_wdata;
	wire pal_entry_t cram_rdata;
	wire pix_index_t pix_idx;
	wire pal_entry_t pix_entry;
	wire pal_entry_t entry;
	wire             blank_q;
	wire             line_q;

	video_regs video_regs_inst (
		.clk        (clk),
		.reset      (reset),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.vga_on     (vga_on),
		.hires      (hires),
		.cram_we    (cram_we),
		.cram_addr  (cram_addr),
		.cram_wdata (cram_wdata),
		.cram_rdata (cram_rdata)
	);

	video_cram video_cram_inst (
		.clk     (clk),
		.a_we    (cram_we),
		.a_addr  (cram_addr),
		.a_wdata (cram_wdata),
		.a_rdata (cram_rdata),
		.b_addr  (pix_idx),
		.b_rdata (pix_entry)
	);

	// stage 1, byte select and palette lookup
	video_pixel_sel video_pixel_sel_inst (
		.clk        (clk),
		.reset      (reset),
		.vga_on     (vga_on),
		.hires      (hires),
		.pix_en     (pix_en),
		.start_out  (start_out),
		.tv_data    (tv_data),
		.vga_data   (vga_data),
		.tv_hblank  (tv_hblank),
		.tv_vblank  (tv_vblank),
		.vga_hblank (vga_hblank),
		.vga_line   (vga_line),
		.pix_idx    (pix_idx),
		.pix_entry  (pix_entry),
		.entry      (entry),
		.blank_q    (blank_q),
		.line_q     (line_q)
	);

	// stage 2, dither and output registers
	video_dither video_dither_inst (
		.clk     (clk),
		.reset   (reset),
		.vga_on  (vga_on),
		.entry   (entry),
		.blank_q (blank_q),
		.line_q  (line_q),
		.vred    (vred),
		.vgrn    (vgrn),
		.vblu    (vblu)
	);

endmodule

`default_nettype wire

// File: design/video_pixel_sel.sv
// Video pixel selector

`default_nettype none
`timescale 1ns/1ns

module video_pixel_sel
	import video_pkg::*;
(
	input  wire             clk,
	input  wire             reset,
	input  wire             vga_on,
	input  wire             hires,
	input  wire             pix_en,
	input  wire             start_out,
	input  wire       [7:0] tv_data,
	input  wire       [7:0] vga_data,
	input  wire             tv_hblank,
	input  wire             tv_vblank,
	input  wire             vga_hblank,
	input  wire             vga_line,
	output pix_index_t      pix_idx,
	input  wire pal_entry_t pix_entry,
	output pal_entry_t      entry,
	output logic            blank_q,
	output logic            line_q
);

	logic       last_low_q;
	logic       sel_low;
	logic [3:0] nibble;
	logic       blank;

	// start forces the high nibble, otherwise each pix_en flips the last choice
	assign sel_low = pix_en ? (start_out ? 1'b0 : ~last_low_q) : last_low_q;
	assign nibble  = sel_low ? vga_data[3:0] : vga_data[7:4];

	// hires pixels use palette entries F0..FF
	assign pix_idx = vga_on ? (hires ? {4'hf, nibble} : vga_data) : tv_data;

	assign blank = vga_on ? (vga_hblank | tv_vblank) : (tv_hblank | tv_vblank);

	always_ff @(posedge clk)
	begin
		if (reset)
			last_low_q <= 1'b1;
		else
			last_low_q <= sel_low;
	end

	// flags follow the CRAM read by one cycle
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			blank_q <= 1'b0;
			line_q  <= 1'b0;
		end
		else
		begin
			blank_q <= blank;
			line_q  <= vga_line;
		end
	end

	assign entry = blank_q ? '0 : pix_entry;

endmodule

`default_nettype wire

// File: design/video_pkg.sv
// Video output types

`default_nettype none

`include "video_params.svh"

package video_pkg;

	// one palette entry, per channel a coarse level and a fine intensity
	// fine selects one of eight PWM dither patterns
	typedef struct packed
	{
		logic [1:0] r_coarse;
		logic [2:0] r_fine;
		logic [1:0] g_coarse;
		logic [2:0] g_fine;
		logic [1:0] b_coarse;
		logic [2:0] b_fine;
	} pal_entry_t;

	// palette index, wide enough for the whole CRAM
	typedef logic [$clog2(`VIDEO_CRAM_DEPTH)-1:0] pix_index_t;

endpackage

`default_nettype wire

// File: design/video_regs.sv
// Video APB register block

`default_nettype none
`timescale 1ns/1ns

`include "video_params.svh"

module video_regs
	import video_pkg::*;
(
	input  wire         clk,
	input  wire         reset,
	input  wire  [11:0] paddr,
	input  wire         psel,
	input  wire         penable,
	input  wire         pwrite,
	input  wire  [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output logic        vga_on,
	output logic        hires,
	output logic        cram_we,
	output pix_index_t  cram_addr,
	output pal_entry_t  cram_wdata,
	input  wire pal_entry_t cram_rdata
);

	logic        apb_xfer;
	logic        ctrl_hit;
	logic        cram_hit;
	logic [11:0] cram_off;

	// no wait states
	assign pready = 1'b1;

	assign apb_xfer = psel & penable & pready;

	// offset into the CRAM window, wraps below the base so it misses
	assign cram_off = paddr - `VIDEO_ADDR_CRAM;
	assign ctrl_hit = (paddr == `VIDEO_ADDR_CTRL);
	assign cram_hit = (cram_off < 12'(4 * `VIDEO_CRAM_DEPTH));

	assign pslverr = apb_xfer & ~(ctrl_hit | cram_hit);

	// address is live in the setup phase so the registered read lands in access
	assign cram_addr  = cram_off[$bits(pix_index_t)+1:2];
	assign cram_we    = apb_xfer & pwrite & cram_hit;
	assign cram_wdata = pal_entry_t'(pwdata[$bits(pal_entry_t)-1:0]);

	// mode bits
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			vga_on <= 1'b0;
			hires  <= 1'b0;
		end
		else if (apb_xfer && pwrite && ctrl_hit)
		begin
			vga_on <= pwdata[0];
			hires  <= pwdata[1];
		end
	end

	// read data mux
	always_comb
	begin
		prdata = 32'd0;
		if (ctrl_hit)
			prdata = {30'd0, hires, vga_on};
		else if (cram_hit)
			prdata = {{(32 - $bits(pal_entry_t)){1'b0}}, cram_rdata};
	end

endmodule

`default_nettype wire

// File: include/video_params.svh
// Video output parameters

`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

// number of palette entries in the colour RAM
`define VIDEO_CRAM_DEPTH 256

// APB register map
`define VIDEO_ADDR_CTRL 12'h000

// CRAM window, entry n lives at base + 4n
`define VIDEO_ADDR_CRAM 12'h400

// cycles from pixel input to colour output
`define VIDEO_LATENCY 2

`endif

// File: tb/video_out_checker.sv
// Video output assertions

`default_nettype none
`timescale 1ns/1ns

`include "video_params.svh"

module video_out_checker (
	input wire       clk,
	input wire       reset,
	input wire       psel,
	input wire       penable,
	input wire       pready,
	input wire       pslverr,
	input wire       vga_on,
	input wire       tv_hblank,
	input wire       tv_vblank,
	input wire       vga_hblank,
	input wire [1:0] vred,
	input wire [1:0] vgrn,
	input wire [1:0] vblu
);

	int fails = 0;

	logic blank_in;

	// blank sources that apply in the current mode
	assign blank_in = vga_on ? (vga_hblank | tv_vblank) : (tv_hblank | tv_vblank);

	pready_high: assert property (@(posedge clk) disable iff (reset) pready)
	else
	begin
		fails++;
		$error("pready went low");
	end

	err_in_access: assert property (@(posedge clk) disable iff (reset)
		pslverr |-> (psel && penable))
	else
	begin
		fails++;
		$error("pslverr high outside an access phase");
	end

	blank_black: assert property (@(posedge clk) disable iff (reset)
		blank_in |-> ##`VIDEO_LATENCY (vred == 2'd0 && vgrn == 2'd0 && vblu == 2'd0))
	else
	begin
		fails++;
		$error("colour not black after a blanked pixel");
	end

endmodule

bind video_out_top video_out_checker video_out_checker_inst (.*);

`default_nettype wire

// File: tb/video_out_tb.sv
// Video output stage testbench

`default_nettype none
`timescale 1ns/1ns

`include "video_params.svh"

module video_out_tb
	import video_pkg::*;
();

	localparam int MAX_ROWS    = 40;
	localparam int NUM_ENTRIES = 48;

	logic        clk;
	logic        reset;
	logic [11:0] paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	wire  [31:0] prdata;
	wire         pready;
	wire         pslverr;
	logic        pix_en;
	logic        start_out;
	logic  [7:0] tv_data;
	logic  [7:0] vga_data;
	logic        tv_hblank;
	logic        tv_vblank;
	logic        vga_hblank;
	logic        vga_line;
	wire   [1:0] vred;
	wire   [1:0] vgrn;
	wire   [1:0] vblu;

	// stimulus table with bits {tv, vga, tvh, tvv, vgah, line, pix_en, start}
	string       row_name [MAX_ROWS];
	logic  [1:0] row_mode [MAX_ROWS];
	logic [21:0] row_bits [MAX_ROWS];
	int          row_reps [MAX_ROWS];
	int          num_rows = 0;
	int          total_reps = 0;
	logic        table_built = 1'b0;

	// reference model state
	pal_entry_t  cram_model [`VIDEO_CRAM_DEPTH];
	logic  [7:0] dith_pat [8] = '{8'h00, 8'h01, 8'h41, 8'h45, 8'ha5, 8'ha7, 8'hd7, 8'hdf};
	logic  [1:0] cur_mode = 2'b00;
	logic        last_low = 1'b1;
	int          cyc = 0;
	integer      seed = 32'h81e8_02c9;
	string       exp_name [$];
	logic  [5:0] exp_rgb [$];
	int          errors = 0;
	int          checks = 0;

	video_out_top video_out_top_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// rising edges since reset release give the dither phase
	always @(posedge clk)
	begin
		if (reset)
			cyc <= 0;
		else
			cyc <= cyc + 1;
	end

	task automatic add_row(input string name, input logic [1:0] mode, input logic [7:0] tv,
		input logic [7:0] vga, input logic [3:0] flags, input logic [1:0] en, input int reps);
		row_name[num_rows] = name;
		row_mode[num_rows] = mode;
		row_bits[num_rows] = {tv, vga, flags, en};
		row_reps[num_rows] = reps;
		total_reps += reps;
		num_rows++;
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
		end
	endtask

	// fixed entries cover every fine value and coarse 3 and the rest are random
	function automatic pal_entry_t make_entry(input logic [7:0] idx);
		logic [31:0] r;
		if (idx < 8)
			return {2'd0, idx[2:0], 2'd1, idx[2:0], 2'd2, idx[2:0]};
		if (idx < 16)
			return {2'd3, idx[2:0], 2'd3, idx[2:0], 2'd3, idx[2:0]};
		r = $random(seed);
		return r[14:0];
	endfunction

	// coarse level plus the pattern bit clipped at the top DAC level
	function automatic logic [1:0] chan_level(input logic [1:0] coarse, input logic [2:0] fine,
		input logic [2:0] ph);
		int lvl;
		lvl = coarse + dith_pat[fine][ph];
		return (lvl > 3) ? 2'd3 : lvl[1:0];
	endfunction

	task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] data,
		input logic err_exp, output logic [31:0] rdata);
		@(negedge clk);
		checks++;
		if (pslverr !== 1'b0)
		begin
			errors++;
			$display("pslverr stuck high while the bus is idle");
		end
		paddr   = addr;
		pwrite  = wr;
		pwdata  = data;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		// access phase still holds after the transfer edge
		@(negedge clk);
		rdata = prdata;
		checks++;
		if (pslverr !== err_exp)
		begin
			errors++;
			$display("unexpected pslverr %b at address %h", pslverr, addr);
		end
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, input logic err);
		logic [31:0] rd_ignored;
		apb_xfer(1'b1, addr, data, err, rd_ignored);
	endtask

	task automatic apb_read(input logic [11:0] addr, input logic err, output logic [31:0] data);
		apb_xfer(1'b0, addr, 32'd0, err, data);
	endtask

	// drive one pixel and queue the colour it must produce
	task automatic drive_pixel(input int r);
		logic       use_low;
		logic [7:0] idx;
		logic [2:0] ph;
		pal_entry_t e;
		{tv_data, vga_data, tv_hblank, tv_vblank, vga_hblank, vga_line, pix_en, start_out} =
			row_bits[r];
		use_low = pix_en ? (!start_out && !last_low) : last_low;
		last_low = use_low;
		if (!cur_mode[0])
			idx = tv_data;
		else if (cur_mode[1])
			idx = {4'hf, use_low ? vga_data[3:0] : vga_data[7:4]};
		else
			idx = vga_data;
		// stage 2 registers on the edge after the sampling edge
		ph = 3'(cyc + 1);
		if (cur_mode[0])
			ph[2] = vga_line;
		e = cram_model[idx];
		exp_name.push_back(row_name[r]);
		if (cur_mode[0] ? (vga_hblank || tv_vblank) : (tv_hblank || tv_vblank))
			exp_rgb.push_back(6'd0);
		else
			exp_rgb.push_back({chan_level(e.r_coarse, e.r_fine, ph),
				chan_level(e.g_coarse, e.g_fine, ph), chan_level(e.b_coarse, e.b_fine, ph)});
	endtask

	task automatic check_output();
		check_val(exp_name.pop_front(), exp_rgb.pop_front(), {vred, vgrn, vblu});
	endtask

	task automatic pixel_cycle(input int r);
		@(negedge clk);
		if (exp_rgb.size() == `VIDEO_LATENCY)
			check_output();
		drive_pixel(r);
	endtask

	task automatic flush_pipe();
		repeat (`VIDEO_LATENCY)
		begin
			@(negedge clk);
			if (exp_rgb.size() != 0)
				check_output();
			pix_en    = 1'b0;
			start_out = 1'b0;
		end
	endtask

	task automatic build_table();
		for (int k = 0; k < 16; k++)
			add_row($sformatf("%s_%0d", k < 8 ? "tv_fine" : "tv_sat", k), 2'b00, 8'(k), 8'h00,
				4'b0000, 2'b00, 8);
		add_row("tv_random", 2'b00, 8'h13, 8'h00, 4'b0000, 2'b00, 8);
		add_row("tv_hblank", 2'b00, 8'h07, 8'h00, 4'b1000, 2'b00, 4);
		add_row("tv_vga_hblank_ignored", 2'b00, 8'h07, 8'h00, 4'b0010, 2'b00, 8);
		add_row("tv_vblank", 2'b00, 8'h07, 8'h00, 4'b0100, 2'b00, 4);
		add_row("vga_line_low", 2'b01, 8'h00, 8'h07, 4'b0000, 2'b00, 8);
		add_row("vga_line_high", 2'b01, 8'h00, 8'h07, 4'b0001, 2'b00, 8);
		add_row("vga_fine5_high", 2'b01, 8'h00, 8'h05, 4'b0001, 2'b00, 4);
		add_row("vga_fine5_low", 2'b01, 8'h00, 8'h05, 4'b0000, 2'b00, 4);
		add_row("vga_hblank", 2'b01, 8'h00, 8'h12, 4'b0010, 2'b00, 4);
		add_row("vga_tv_hblank_ignored", 2'b01, 8'h00, 8'h12, 4'b1000, 2'b00, 8);
		add_row("vga_vblank", 2'b01, 8'h00, 8'h12, 4'b0100, 2'b00, 4);
		add_row("hires_start", 2'b11, 8'h00, 8'ha3, 4'b0000, 2'b11, 1);
		// even count leaves the high nibble selected before the restart
		add_row("hires_alternate", 2'b11, 8'h00, 8'ha3, 4'b0000, 2'b10, 6);
		add_row("hires_hold", 2'b11, 8'h00, 8'h5c, 4'b0000, 2'b00, 4);
		add_row("hires_restart", 2'b11, 8'h00, 8'h5c, 4'b0000, 2'b11, 1);
		add_row("hires_alternate2", 2'b11, 8'h00, 8'h9e, 4'b0000, 2'b10, 6);
		add_row("hires_blank", 2'b11, 8'h00, 8'h9e, 4'b0010, 2'b10, 3);
	endtask

	initial
	begin
		logic  [7:0] idx;
		logic [31:0] rd;
		reset      = 1'b1;
		paddr      = 12'd0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		pwdata     = 32'd0;
		pix_en     = 1'b0;
		start_out  = 1'b0;
		tv_data    = 8'd0;
		vga_data   = 8'd0;
		tv_hblank  = 1'b0;
		tv_vblank  = 1'b0;
		vga_hblank = 1'b0;
		vga_line   = 1'b0;
		build_table();
		table_built = 1'b1;
		repeat (8) @(negedge clk);
		reset = 1'b0;

		// mode bits read back and the last value written is 0
		for (int v = 3; v >= 0; v--)
		begin
			apb_write(`VIDEO_ADDR_CTRL, 32'(v), 1'b0);
			apb_read(`VIDEO_ADDR_CTRL, 1'b0, rd);
			check_val("ctrl_readback", 32'(v), rd);
		end
		apb_write(12'h100, 32'h3, 1'b1);
		apb_read(12'h010, 1'b1, rd);
		apb_read(`VIDEO_ADDR_CTRL, 1'b0, rd);
		check_val("ctrl_after_unmapped", 32'd0, rd);

		// palette entries 00..1f and f0..ff
		for (int i = 0; i < NUM_ENTRIES; i++)
		begin
			idx = (i < 32) ? 8'(i) : 8'(i + 208);
			cram_model[idx] = make_entry(idx);
			apb_write(`VIDEO_ADDR_CRAM + {2'b00, idx, 2'b00}, {17'd0, cram_model[idx]}, 1'b0);
		end
		for (int i = 0; i < NUM_ENTRIES; i++)
		begin
			idx = (i < 32) ? 8'(i) : 8'(i + 208);
			apb_read(`VIDEO_ADDR_CRAM + {2'b00, idx, 2'b00}, 1'b0, rd);
			check_val($sformatf("cram_readback_%02h", idx), {17'd0, cram_model[idx]}, rd);
		end

		for (int r = 0; r < num_rows; r++)
		begin
			if (row_mode[r] != cur_mode)
			begin
				flush_pipe();
				apb_write(`VIDEO_ADDR_CTRL, {30'd0, row_mode[r]}, 1'b0);
				cur_mode = row_mode[r];
			end
			repeat (row_reps[r])
				pixel_cycle(r);
		end
		flush_pipe();

		errors += video_out_top_inst.video_out_checker_inst.fails;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// watchdog sized from the table and the bus traffic
	initial
	begin
		int limit;
		wait (table_built);
		limit = 8 + total_reps + 3 * (11 + 2 * NUM_ENTRIES + num_rows)
			+ `VIDEO_LATENCY * (num_rows + 1) + 200;
		repeat (limit) @(posedge clk);
		$display("timeout after %0d cycles, the tests did not finish", limit);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
design/video_pkg.sv
design/video_regs.sv
design/video_cram.sv
design/video_pixel_sel.sv
design/video_dither.sv
design/video_out_top.sv
tb/video_out_checker.sv
tb/video_out_tb.sv
